/* rtl/ear_trainer_pkg.sv */
package ear_trainer_pkg;

    // Top level operating mode, value 3 shows blanks
    typedef enum logic [1:0] {
        mode_home         = 2'd0,
        mode_ear_training = 2'd1,
        mode_free_play    = 2'd2
    } mode_t;

    // GPIO word from the soft processor
    localparam int gpio_width     = 32;
    localparam int gpio_mode_lsb  = 0;  // 2 bit mode
    localparam int gpio_note0_lsb = 4;  // Chord note 0, after the note count
    localparam int gpio_sung_lsb  = 25; // Sung note id
    localparam int gpio_cmp_bit   = 31; // Compare correct

    // Note ids
    localparam int note_id_width     = 7;
    localparam int sung_id_width     = 6;
    localparam int note_range_offset = 27; // C3 is id 28
    localparam int notes_per_octave  = 12;

    // Clocks per period at 100 MHz, C first
    localparam logic [31:0] base_clks_per_period [notes_per_octave] = '{
        32'd3057805, // C
        32'd2886184, // C#
        32'd2724194, // D
        32'd2571298, // D#
        32'd2426982, // E
        32'd2290765, // F
        32'd2162195, // F#
        32'd2040840, // G
        32'd1926296, // G#
        32'd1818182, // A
        32'd1716135, // A#
        32'd1619816  // B
    };

    localparam int volume_width = 4;
    localparam int volume_max   = 15;

    // ASCII codes shown on the display
    typedef logic [7:0] char_t;
    localparam char_t char_space = 8'h20;
    localparam char_t char_qmark = 8'h3f;
    localparam char_t char_minus = 8'h2d;
    localparam char_t char_sharp = 8'h27; // Apostrophe marks a sharp
    localparam char_t char_a     = 8'h41;
    localparam char_t char_b     = 8'h42;
    localparam char_t char_c     = 8'h43;
    localparam char_t char_d     = 8'h44;
    localparam char_t char_e     = 8'h45;
    localparam char_t char_f     = 8'h46;
    localparam char_t char_g     = 8'h47;
    localparam char_t char_h     = 8'h48;
    localparam char_t char_o     = 8'h4f;
    localparam char_t char_p     = 8'h50;
    localparam char_t char_s     = 8'h53;
    localparam char_t char_t_    = 8'h54;

    // Note id to octave index, 1 = C .. 12 = B, 0 = no note
    function automatic logic [3:0] octave_index(input logic [note_id_width-1:0] note_id);
        logic [note_id_width-1:0] diff;
        diff = note_id - note_id_width'(note_range_offset);
        if (diff >= 1 && diff <= notes_per_octave) return diff[3:0];
        return 4'd0;
    endfunction

    // ASCII to active-low segments, bit order g f e d c b a
    function automatic logic [6:0] seg7_font(input char_t ch);
        case (ch)
            char_a:  return 7'b0001000;
            char_b:  return 7'b0000011; // Lower case b shape
            char_c:  return 7'b1000110;
            char_d:  return 7'b0100001; // Lower case d shape
            char_e:  return 7'b0000110;
            char_f:  return 7'b0001110;
            char_g:  return 7'b1000010;
            char_h:  return 7'b0001001;
            char_o:  return 7'b1000000;
            char_p:  return 7'b0001100;
            char_s:  return 7'b0010010;
            char_t_: return 7'b0000111; // Lower case t shape
            char_qmark: return 7'b0101100;
            char_minus: return 7'b0111111;
            char_sharp: return 7'b1111101; // Segment b only
            default: return 7'b1111111;    // Space and unknown codes are dark
        endcase
    endfunction

endpackage

/* rtl/display_text.sv */
`timescale 1ns/1ps

module display_text
    import ear_trainer_pkg::*;
(
    input  logic                     CLK100MHZ,
    input  logic                     CPU_RESETN,
    input  mode_t                    mode,
    input  logic [sung_id_width-1:0] sung_id,
    input  logic                     compare_ok,
    output char_t [7:0]              text       // text[7] is the leftmost digit
);

    // Registered copies of the displayed inputs
    mode_t                    mode_q;
    logic [sung_id_width-1:0] sung_q;
    logic                     cmp_q;
    logic                     text_update; // One cycle change flag

    logic [3:0]  sung_idx;
    char_t       mode_l, mode_r;
    char_t       note_l, note_r;
    char_t       sung_letter, sung_mark;
    char_t [7:0] next_text;

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            mode_q      <= mode_home;
            sung_q      <= '0;
            cmp_q       <= 1'b0;
            text_update <= 1'b0;
        end else begin
            text_update <= (mode != mode_q) || (sung_id != sung_q) || (compare_ok != cmp_q);
            mode_q      <= mode; // Updated every cycle
            sung_q      <= sung_id;
            cmp_q       <= compare_ok;
        end
    end

    assign sung_idx = octave_index({1'b0, sung_q});

    // Sung note name and sharp mark
    always_comb begin
        sung_mark = char_space;
        case (sung_idx)
            4'd1, 4'd2:  sung_letter = char_c;
            4'd3, 4'd4:  sung_letter = char_d;
            4'd5:        sung_letter = char_e;
            4'd6, 4'd7:  sung_letter = char_f;
            4'd8, 4'd9:  sung_letter = char_g;
            4'd10, 4'd11: sung_letter = char_a;
            4'd12:       sung_letter = char_b;
            default:     sung_letter = char_space; // No note
        endcase
        if (sung_idx inside {4'd2, 4'd4, 4'd7, 4'd9, 4'd11}) begin
            sung_mark = char_sharp;
        end
    end

    // Mode letters and note field
    always_comb begin
        mode_l = char_space;
        mode_r = char_space;
        note_l = char_space;
        note_r = char_space;
        case (mode_q)
            mode_home: begin
                mode_l = char_h;
                mode_r = char_s;
            end
            mode_ear_training: begin
                mode_l = char_e;
                mode_r = char_t_;
                note_l = char_qmark; // Hidden answer
                note_r = char_qmark;
            end
            mode_free_play: begin
                mode_l = char_f;
                mode_r = char_p;
                note_l = sung_letter;
                note_r = sung_mark;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_text    = {8{char_space}};
        next_text[7] = mode_l;
        next_text[6] = mode_r;
        next_text[4] = cmp_q ? char_o : char_minus; // Compare symbol
        next_text[3] = note_l;
        next_text[2] = note_r;
    end

    // Display register, loaded the cycle after a change
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            text <= {8{char_space}};
        end else if (text_update) begin
            text <= next_text;
        end
    end

    a_text_on_update: assert property (@(posedge CLK100MHZ) disable iff (!CPU_RESETN)
        !$stable(text) |-> $past(text_update));

endmodule

/* rtl/tone_generator.sv */
`timescale 1ns/1ps

module tone_generator
    import ear_trainer_pkg::*;
#(
    parameter int unsigned octave_shift = 3 // Divides the base period down the octaves
) (
    input  logic                     CLK100MHZ,
    input  logic                     CPU_RESETN,
    input  logic [note_id_width-1:0] play_note_id,
    input  logic [volume_width-1:0]  volume,
    output logic                     tone
);

    logic [3:0]              note_idx;
    logic                    note_valid;
    logic [31:0]             base_period;
    logic [31:0]             period;      // Cycles per tone period
    logic [31:0]             prev_period;
    logic                    period_restart;
    logic [31:0]             period_cnt;
    logic [volume_width-1:0] vol_cnt;     // Free running duty counter

    assign note_idx   = octave_index(play_note_id);
    assign note_valid = (note_idx != 4'd0);

    // Period table lookup
    always_comb begin
        base_period = '0;
        if (note_valid) begin
            base_period = base_clks_per_period[note_idx - 4'd1];
        end
    end

    assign period = base_period >> octave_shift;

    // Restart the counter one cycle after a period change
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            prev_period    <= '0;
            period_restart <= 1'b0;
        end else begin
            prev_period    <= period;
            period_restart <= (period != prev_period);
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            period_cnt <= '0;
        end else if (period_restart || period == '0) begin
            period_cnt <= '0;
        end else if (period_cnt >= period - 32'd1) begin
            period_cnt <= '0; // End of period
        end else begin
            period_cnt <= period_cnt + 32'd1;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            vol_cnt <= '0;
        end else begin
            vol_cnt <= vol_cnt + 1'b1;
        end
    end

    // High half of the period, chopped by the volume duty
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            tone <= 1'b0;
        end else begin
            tone <= note_valid && (period_cnt < (period >> 1)) && (vol_cnt < volume);
        end
    end

    // Once the period has settled the counter must be in range
    a_cnt_in_period: assert property (@(posedge CLK100MHZ) disable iff (!CPU_RESETN)
        (period != '0 && period == prev_period) |-> (period_cnt < period));

endmodule

/* rtl/volume_control.sv */
`timescale 1ns/1ps

module volume_control
    import ear_trainer_pkg::*;
(
    input  logic                    CLK100MHZ,
    input  logic                    CPU_RESETN,
    input  logic                    btnu,
    input  logic                    btnd,
    output logic [volume_width-1:0] volume
);

    logic btnu_q, btnd_q; // Previous button levels
    logic up_edge, down_edge;

    assign up_edge   = btnu && !btnu_q;
    assign down_edge = btnd && !btnd_q;

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            btnu_q <= 1'b0;
            btnd_q <= 1'b0;
            volume <= '0;
        end else begin
            btnu_q <= btnu;
            btnd_q <= btnd;
            if (up_edge) begin // Up wins over down
                if (volume != volume_width'(volume_max)) volume <= volume + 1'b1;
            end else if (down_edge) begin
                if (volume != '0) volume <= volume - 1'b1;
            end
        end
    end

    // Saturation, no wrap in either direction
    a_no_wrap_up: assert property (@(posedge CLK100MHZ) disable iff (!CPU_RESETN)
        (volume == volume_width'(volume_max)) |=> (volume != '0));
    a_no_wrap_down: assert property (@(posedge CLK100MHZ) disable iff (!CPU_RESETN)
        (volume == '0) |=> (volume != volume_width'(volume_max)));

endmodule

/* rtl/seg7_scanner.sv */
`timescale 1ns/1ps

module seg7_scanner
    import ear_trainer_pkg::*;
#(
    parameter int unsigned scan_div_log2 = 17 // Cycles per digit as a power of two
) (
    input  logic        CLK100MHZ,
    input  logic        CPU_RESETN,
    input  char_t [7:0] text,
    output logic [6:0]  seg7_seg,   // Active low, g f e d c b a
    output logic [7:0]  seg7_an     // Active low anodes
);

    logic [scan_div_log2-1:0] scan_div;
    logic                     scan_tick;
    logic [2:0]               digit;      // Active digit, 0 is rightmost
    char_t                    digit_char;

    assign scan_tick = &scan_div;

    // Digit refresh divider
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            scan_div <= '0;
        end else begin
            scan_div <= scan_div + 1'b1;
        end
    end

    // Digit index, wraps 7 back to 0
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            digit <= 3'd0;
        end else if (scan_tick) begin
            digit <= digit + 3'd1;
        end
    end

    // One anode low
    always_comb begin
        seg7_an        = 8'hff;
        seg7_an[digit] = 1'b0;
    end

    // Segments for the same digit, no extra register stage
    assign digit_char = text[digit];
    assign seg7_seg   = seg7_font(digit_char);

    a_one_anode: assert property (@(posedge CLK100MHZ) disable iff (!CPU_RESETN)
        $onehot(~seg7_an));

endmodule

/* rtl/ear_trainer_top.sv */
`timescale 1ns/1ps

module ear_trainer_top
    import ear_trainer_pkg::*;
#(
    parameter int unsigned octave_shift  = 3,
    parameter int unsigned scan_div_log2 = 17
) (
    input  logic                  CLK100MHZ,
    input  logic                  CPU_RESETN,
    input  logic                  play_en,     // Switch, also audio amp enable
    input  logic                  btnu,
    input  logic                  btnd,
    input  logic [gpio_width-1:0] axi_gpio_in,
    output logic                  aud_pwm,
    output logic                  aud_sd,
    output logic                  seg7_dp,
    output logic [6:0]            seg7_seg,
    output logic [7:0]            seg7_an
);

    mode_t                    mode;
    logic [note_id_width-1:0] play_note_id;
    logic [sung_id_width-1:0] sung_id;
    logic                     compare_ok;
    logic [volume_width-1:0]  volume;
    logic                     tone;
    char_t [7:0]              text;

    // GPIO fields, note count and chord notes 1 and 2 unused
    assign mode         = mode_t'(axi_gpio_in[gpio_mode_lsb +: 2]);
    assign play_note_id = axi_gpio_in[gpio_note0_lsb +: note_id_width];
    assign sung_id      = axi_gpio_in[gpio_sung_lsb +: sung_id_width];
    assign compare_ok   = axi_gpio_in[gpio_cmp_bit];

    display_text i_display_text (
        .CLK100MHZ  (CLK100MHZ),
        .CPU_RESETN (CPU_RESETN),
        .mode       (mode),
        .sung_id    (sung_id),
        .compare_ok (compare_ok),
        .text       (text)
    );

    volume_control i_volume_control (
        .CLK100MHZ  (CLK100MHZ),
        .CPU_RESETN (CPU_RESETN),
        .btnu       (btnu),
        .btnd       (btnd),
        .volume     (volume)
    );

    tone_generator #(
        .octave_shift (octave_shift)
    ) i_tone_generator (
        .CLK100MHZ    (CLK100MHZ),
        .CPU_RESETN   (CPU_RESETN),
        .play_note_id (play_note_id),
        .volume       (volume),
        .tone         (tone)
    );

    seg7_scanner #(
        .scan_div_log2 (scan_div_log2)
    ) i_seg7_scanner (
        .CLK100MHZ  (CLK100MHZ),
        .CPU_RESETN (CPU_RESETN),
        .text       (text),
        .seg7_seg   (seg7_seg),
        .seg7_an    (seg7_an)
    );

    // Tone only in Ear Training, driven 1/0 rather than open drain
    assign aud_pwm = tone && play_en && (mode == mode_ear_training);
    assign aud_sd  = play_en;
    assign seg7_dp = 1'b1; // Decimal points dark

endmodule

/* verification/tb_ear_trainer.sv */
`timescale 1ns/1ps

module tb_ear_trainer;

    localparam int octave_shift   = 14;
    localparam int period_cycles  = 3057805 >> octave_shift; // Note C, 186 cycles
    localparam int measure_cycles = 32 * period_cycles;
    localparam int gate_cycles    = 2 * period_cycles;
    localparam int read_limit     = 80;                      // Full scan is 32 cycles
    // Test lengths in cycles, used for the timeout
    localparam int display_cycles = (1 + 4 + 13) * (read_limit + 4);
    localparam int volume_cycles  = 23 * 3 + 2 * (measure_cycles + 4);
    localparam int gating_cycles  = 5 * (gate_cycles + 4);
    localparam int timeout_cycles = (10 + display_cycles + volume_cycles + gating_cycles) * 3 / 2;

    logic        CLK100MHZ = 1'b0;
    logic        CPU_RESETN;
    logic        play_en;
    logic        btnu;
    logic        btnd;
    logic [31:0] axi_gpio_in;
    logic        aud_pwm;
    logic        aud_sd;
    logic        seg7_dp;
    logic [6:0]  seg7_seg;
    logic [7:0]  seg7_an;

    logic [7:0]  shown [8];       // Characters read back from the pins
    logic [7:0]  expect_text [8];
    logic [31:0] lfsr_state = 32'hd0d7_8fa8;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;

    ear_trainer_top #(
        .octave_shift  (octave_shift),
        .scan_div_log2 (2)
    ) i_ear_trainer_top (
        .CLK100MHZ   (CLK100MHZ),
        .CPU_RESETN  (CPU_RESETN),
        .play_en     (play_en),
        .btnu        (btnu),
        .btnd        (btnd),
        .axi_gpio_in (axi_gpio_in),
        .aud_pwm     (aud_pwm),
        .aud_sd      (aud_sd),
        .seg7_dp     (seg7_dp),
        .seg7_seg    (seg7_seg),
        .seg7_an     (seg7_an)
    );

    always #5 CLK100MHZ = ~CLK100MHZ; // 100 MHz

    always @(posedge CLK100MHZ) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Active-low segments g f e d c b a back to ASCII
    function automatic logic [7:0] seg_to_char(input logic [6:0] seg);
        case (seg)
            7'b1111111: return " ";
            7'b0001000: return "A";
            7'b0000011: return "B";
            7'b1000110: return "C";
            7'b0100001: return "D";
            7'b0000110: return "E";
            7'b0001110: return "F";
            7'b1000010: return "G";
            7'b0001001: return "H";
            7'b1000000: return "O";
            7'b0001100: return "P";
            7'b0010010: return "S";
            7'b0000111: return "T";
            7'b0101100: return "?";
            7'b0111111: return "-";
            7'b1111101: return "'";
            default:    return "*"; // Not a known shape
        endcase
    endfunction

    // Sung id to note letter and sharp mark
    function automatic logic [15:0] note_name(input int id);
        case (id - 27)
            1:       return "C ";
            2:       return "C'";
            3:       return "D ";
            4:       return "D'";
            5:       return "E ";
            6:       return "F ";
            7:       return "F'";
            8:       return "G ";
            9:       return "G'";
            10:      return "A ";
            11:      return "A'";
            12:      return "B ";
            default: return "  "; // No note
        endcase
    endfunction

    function automatic logic [15:0] mode_letters(input logic [1:0] m);
        case (m)
            2'd0:    return "HS";
            2'd1:    return "ET";
            2'd2:    return "FP";
            default: return "  ";
        endcase
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %0t: %s expected %0h got %0h", $time, name, exp, act);
        value_errors++;
    endtask

    // GPIO word: cmp, sung, chord 2, chord 1, chord 0, count, mode
    task automatic drive_gpio(input logic [1:0] m, input logic [6:0] note,
                              input logic [5:0] sung, input logic cmp);
        @(posedge CLK100MHZ);
        #1;
        axi_gpio_in = {cmp, sung, 14'd0, note, 2'd0, m};
    endtask

    task automatic press_button(input bit down);
        @(posedge CLK100MHZ);
        #1;
        if (down) btnd = 1'b1;
        else btnu = 1'b1;
        @(posedge CLK100MHZ);
        #1;
        btnu = 1'b0;
        btnd = 1'b0;
        @(posedge CLK100MHZ); // Release seen by the edge detector
    endtask

    // Follow the scan until all eight digits are seen
    task automatic read_display();
        logic [7:0] seen;
        int         n;
        seen = '0;
        n = 0;
        while (seen != 8'hff && n < read_limit) begin
            @(negedge CLK100MHZ);
            n++;
            if ($countones(~seg7_an) != 1) begin
                $display("Anode fault at %0t: seg7_an %b has no single active digit",
                         $time, seg7_an);
                other_errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    if (!seg7_an[i]) begin
                        shown[i] = seg_to_char(seg7_seg);
                        seen[i]  = 1'b1;
                    end
                end
            end
        end
        if (seen != 8'hff) begin
            $display("Display scan stalled: only digits %b were seen", seen);
            other_errors++;
        end
    endtask

    task automatic check_text(input string where);
        for (int i = 0; i < 8; i++) begin
            if (shown[i] !== expect_text[i]) begin
                report_value($sformatf("digit %0d (%s)", i, where), expect_text[i], shown[i]);
            end
        end
    endtask

    task automatic count_high_cycles(input int cycles, output int count);
        count = 0;
        repeat (cycles) begin
            @(negedge CLK100MHZ);
            if (aud_pwm) count++;
        end
    endtask

    task automatic reset_state();
        @(negedge CLK100MHZ);
        if (aud_pwm !== 1'b0) report_value("aud_pwm", 0, aud_pwm);
        if (aud_sd !== play_en) report_value("aud_sd", play_en, aud_sd);
        if (seg7_dp !== 1'b1) report_value("seg7_dp", 1, seg7_dp); // Decimal points dark
        @(posedge CLK100MHZ);
        #1;
        play_en = 1'b1;
        @(negedge CLK100MHZ);
        if (aud_sd !== 1'b1) report_value("aud_sd", 1, aud_sd);
        if (aud_pwm !== 1'b0) report_value("aud_pwm", 0, aud_pwm); // Home mode, no tone
        @(posedge CLK100MHZ);
        #1;
        play_en = 1'b0;
        read_display();
        for (int i = 0; i < 8; i++) expect_text[i] = " ";
        check_text("reset");
    endtask

    // Mode 0 last, it matches the reset value of the input registers
    task automatic mode_text();
        logic [1:0]  m;
        logic [15:0] letters;
        for (int i = 0; i < 4; i++) begin
            m = 2'(i + 1);
            drive_gpio(m, 7'd0, 6'd0, 1'b0);
            repeat (3) @(posedge CLK100MHZ); // Text follows two cycles later
            read_display();
            letters = mode_letters(m);
            for (int k = 0; k < 8; k++) expect_text[k] = " ";
            expect_text[7] = letters[15:8];
            expect_text[6] = letters[7:0];
            expect_text[4] = "-";
            if (m == 2'd1) begin
                expect_text[3] = "?";
                expect_text[2] = "?";
            end
            check_text($sformatf("mode %0d", m));
        end
    endtask

    task automatic free_play_notes();
        int          id;
        logic        cmp;
        logic [15:0] name;
        for (int i = 0; i < 13; i++) begin
            id  = (i < 12) ? 28 + int'(lfsr_bits(4) % 12) : 40; // Last id is out of range
            cmp = lfsr_bits(1);
            drive_gpio(2'd2, 7'd0, 6'(id), cmp);
            repeat (3) @(posedge CLK100MHZ);
            read_display();
            name = note_name(id);
            for (int k = 0; k < 8; k++) expect_text[k] = " ";
            expect_text[7] = "F";
            expect_text[6] = "P";
            expect_text[4] = cmp ? "O" : "-";
            expect_text[3] = name[15:8];
            expect_text[2] = name[7:0];
            check_text($sformatf("sung id %0d", id));
        end
    endtask

    // Volume is seen only through the duty of the tone
    task automatic volume_and_tone();
        int count;
        int expected;
        drive_gpio(2'd1, 7'd28, 6'd0, 1'b0);
        play_en = 1'b1;
        repeat (4) @(posedge CLK100MHZ); // Period restart settles
        press_button(1'b1);              // Down at 0 must stay at 0
        count_high_cycles(measure_cycles, count);
        if (count != 0) report_value("aud_pwm high cycles at volume 0", 0, count);
        repeat (17) press_button(1'b0);
        repeat (2) press_button(1'b1);
        count_high_cycles(measure_cycles, count);
        expected = (measure_cycles / 2) * 13 / 16;
        if ((count - expected) * 10 > expected || (expected - count) * 10 > expected) begin
            report_value("aud_pwm high cycles at volume 13", expected, count);
        end
    endtask

    task automatic audio_gating();
        logic [1:0] modes [5] = '{2'd2, 2'd0, 2'd1, 2'd3, 2'd1};
        logic       enables [5] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
        logic [6:0] notes [5] = '{7'd28, 7'd28, 7'd28, 7'd28, 7'd27};
        int         count;
        repeat (2) press_button(1'b0); // 13 up to 15
        for (int i = 0; i < 5; i++) begin
            drive_gpio(modes[i], notes[i], 6'd0, 1'b0);
            play_en = enables[i];
            repeat (3) @(posedge CLK100MHZ);
            count_high_cycles(gate_cycles, count);
            if (count != 0) report_value($sformatf("aud_pwm high cycles, case %0d", i), 0, count);
            if (aud_sd !== enables[i]) report_value("aud_sd", enables[i], aud_sd);
        end
    endtask

    initial begin
        CPU_RESETN  = 1'b0;
        play_en     = 1'b0;
        btnu        = 1'b0;
        btnd        = 1'b0;
        axi_gpio_in = '0;
        repeat (5) @(posedge CLK100MHZ);
        #1;
        CPU_RESETN = 1'b1;
        reset_state();
        mode_text();
        free_play_notes();
        volume_and_tone();
        audio_gating();
        $display("Summary: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/ear_trainer_pkg.sv
rtl/display_text.sv
rtl/tone_generator.sv
rtl/volume_control.sv
rtl/seg7_scanner.sv
rtl/ear_trainer_top.sv
verification/tb_ear_trainer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ear trainer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_ear_trainer \
    -Mdir obj_dir \
    -f list.f

out=$(./obj_dir/Vtb_ear_trainer)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
